// File: logic/isa_pkg.sv
package isa_pkg;

    // base widths of the rv32 integer isa
    localparam int XLEN    = 32;
    localparam int INSTR_W = 32;

    typedef logic [XLEN-1:0]    addr_t;    // byte address
    typedef logic [INSTR_W-1:0] instr_t;   // one uncompressed instruction

    // opcode field sits in the low bits of every format
    localparam int OPC_W = 7;
    typedef logic [OPC_W-1:0] opcode_t;

    localparam opcode_t OPC_BRANCH = 7'b110_0011;  // beq/bne/blt/bge/bltu/bgeu
    localparam opcode_t OPC_JAL    = 7'b110_1111;  // jal, pc relative

    // imm[12] of b-type and imm[20] of j-type both live here
    // so the offset sign is known without rebuilding the immediate
    localparam int SIGN_BIT = 31;

    // sequential step, no compressed support
    localparam addr_t INSTR_BYTES = 32'd4;

endpackage

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // cache block holds two aligned instruction words
    localparam int INSTRS_PER_BLOCK = 2;
    localparam int BLOCK_W          = INSTRS_PER_BLOCK * isa_pkg::INSTR_W;
    typedef logic [BLOCK_W-1:0] block_t;

    // byte offset bits inside a block, 3 for 8 bytes
    localparam int OFFSET_W = $clog2(BLOCK_W / 8);

    // direct mapped geometry
    localparam int ICACHE_SETS = 16;
    localparam int INDEX_W     = $clog2(ICACHE_SETS);
    typedef logic [INDEX_W-1:0] index_t;

    localparam int TAG_W = isa_pkg::XLEN - INDEX_W - OFFSET_W;  // 25
    typedef logic [TAG_W-1:0] tag_t;

    // instruction queue towards dispatch
    localparam int IFIFO_DEPTH = 8;
    localparam int IFIFO_PTR_W = $clog2(IFIFO_DEPTH);
    typedef logic [IFIFO_PTR_W-1:0] ifq_ptr_t;
    typedef logic [IFIFO_PTR_W:0]   ifq_cnt_t;   // one extra bit to hold DEPTH

    localparam isa_pkg::addr_t RESET_PC = 32'h0000_1000;

    // one queue entry, 98 bits
    // pred_target is what fetch actually followed after this instr
    typedef struct packed {
        isa_pkg::instr_t instr;
        isa_pkg::addr_t  pc;
        logic            is_cond_br;   // b-type only, jal excluded
        logic            pred_taken;   // static direction guess
        isa_pkg::addr_t  pred_target;  // predicted next pc
    } fetch_entry_t;

endpackage

// File: logic/icache.sv
module icache (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::addr_t    addr,
    input  logic              refill_valid,
    input  fetch_pkg::block_t refill_data,
    output logic              hit,
    output fetch_pkg::block_t block,
    output logic              refill_req,
    output isa_pkg::addr_t    refill_addr
);

    typedef enum logic {
        IDLE,
        WAIT_FILL
    } fill_state_e;

    fill_state_e state_q;
    fill_state_e state_d;

    // line storage
    logic [fetch_pkg::ICACHE_SETS-1:0] valid_q;
    fetch_pkg::tag_t                   tag_q  [fetch_pkg::ICACHE_SETS];
    fetch_pkg::block_t                 data_q [fetch_pkg::ICACHE_SETS];

    fetch_pkg::index_t lookup_idx;
    fetch_pkg::tag_t   lookup_tag;
    fetch_pkg::index_t fill_idx;
    fetch_pkg::tag_t   fill_tag;
    isa_pkg::addr_t    miss_addr_q;   // block aligned address being refilled
    logic              fill_we;

    assign lookup_idx = addr[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
    assign lookup_tag = addr[isa_pkg::XLEN-1 -: fetch_pkg::TAG_W];

    // same cycle lookup
    assign hit   = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign block = data_q[lookup_idx];

    // fill goes to the line that missed, pc may have been redirected since
    assign fill_idx = miss_addr_q[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
    assign fill_tag = miss_addr_q[isa_pkg::XLEN-1 -: fetch_pkg::TAG_W];
    assign fill_we  = (state_q == WAIT_FILL) && refill_valid;

    assign refill_req  = (state_q == WAIT_FILL);
    assign refill_addr = miss_addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (!hit) state_d = WAIT_FILL;       // start refill next cycle
            WAIT_FILL: if (refill_valid) state_d = IDLE;    // line written on this edge
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            valid_q <= '0;   // all lines invalid out of reset
        end else begin
            state_q <= state_d;
            if (fill_we) valid_q[fill_idx] <= 1'b1;
        end
    end

    // capture miss address once, held for the whole request
    always_ff @(posedge clk) begin
        if (state_q == IDLE && !hit) begin
            miss_addr_q <= {addr[isa_pkg::XLEN-1:fetch_pkg::OFFSET_W],
                            {fetch_pkg::OFFSET_W{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= refill_data;
        end
    end

    // request must hold its address until memory answers
    a_refill_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        refill_req && !refill_valid |=> refill_req && $stable(refill_addr))
        else $error("icache: refill request dropped or address changed before response");

    // memory may only answer an outstanding request
    a_no_stray_refill : assert property (@(posedge clk) disable iff (!rst_n)
        refill_valid |-> state_q == WAIT_FILL)
        else $error("icache: refill_valid without pending request");

endmodule

// File: logic/next_pc_predict.sv
module next_pc_predict (
    input  isa_pkg::instr_t instr,
    input  isa_pkg::addr_t  pc,
    output logic            is_cond_br,
    output logic            pred_taken,
    output isa_pkg::addr_t  pred_target
);

    isa_pkg::opcode_t opcode;
    isa_pkg::addr_t   imm_b;
    isa_pkg::addr_t   imm_j;
    isa_pkg::addr_t   offset;
    logic             is_jal;
    logic             sign;

    assign opcode = instr[isa_pkg::OPC_W-1:0];
    assign sign   = instr[isa_pkg::SIGN_BIT];

    // b-type imm[12|10:5|4:1|11], lsb always zero
    assign imm_b = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // j-type imm[20|10:1|11|19:12]
    assign imm_j = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_cond_br = (opcode == isa_pkg::OPC_BRANCH);
    assign is_jal     = (opcode == isa_pkg::OPC_JAL);   // unconditional, not a cond br

    // btfn: backward taken, forward not taken
    assign pred_taken = is_jal || (is_cond_br && sign);

    assign offset = is_jal ? imm_j : imm_b;

    // jalr and everything else falls through
    assign pred_target = pc + (pred_taken ? offset : isa_pkg::INSTR_BYTES);

endmodule

// File: logic/instr_fifo.sv
module instr_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    enq_valid,
    input  fetch_pkg::fetch_entry_t enq_data,
    input  logic                    deq_ready,
    output logic                    enq_ready,
    output logic                    deq_valid,
    output fetch_pkg::fetch_entry_t deq_data
);

    fetch_pkg::fetch_entry_t mem_q [fetch_pkg::IFIFO_DEPTH];

    fetch_pkg::ifq_ptr_t wr_ptr_q;
    fetch_pkg::ifq_ptr_t rd_ptr_q;
    fetch_pkg::ifq_cnt_t count_q;
    logic                full;
    logic                do_enq;
    logic                do_deq;

    assign full      = (count_q == fetch_pkg::ifq_cnt_t'(fetch_pkg::IFIFO_DEPTH));
    assign deq_valid = (count_q != '0);
    assign deq_data  = mem_q[rd_ptr_q];

    // a full queue still takes an entry when the head leaves this cycle
    assign enq_ready = !full || deq_ready;

    assign do_enq = enq_valid && enq_ready;
    assign do_deq = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin    // flush beats enqueue
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps since depth is a power of two
            if (do_deq) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // both or neither
            endcase
        end
    end

    // storage written on enqueue only
    always_ff @(posedge clk) begin
        if (do_enq) mem_q[wr_ptr_q] <= enq_data;
    end

    // producer must not push into a full queue unless the head pops
    a_no_enq_full : assert property (@(posedge clk) disable iff (!rst_n)
        enq_valid && full |-> deq_ready)
        else $error("instr_fifo: enqueue while full");

    // empty means the read pointer caught up with the write pointer
    a_no_deq_empty : assert property (@(posedge clk) disable iff (!rst_n)
        count_q == '0 |-> rd_ptr_q == wr_ptr_q)
        else $error("instr_fifo: dequeue while empty");

endmodule

// File: logic/ifu.sv
module ifu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect_valid,
    input  isa_pkg::addr_t          redirect_pc,
    input  logic                    refill_valid,
    input  fetch_pkg::block_t       refill_data,
    input  logic                    dispatch_ready,
    output logic                    refill_req,
    output isa_pkg::addr_t          refill_addr,
    output logic                    instr_valid,
    output fetch_pkg::fetch_entry_t instr_entry
);

    isa_pkg::addr_t          pc_q;
    isa_pkg::addr_t          pc_d;
    logic                    hit;
    fetch_pkg::block_t       cache_block;
    isa_pkg::instr_t         instr_word;
    logic                    slot;          // which word of the block
    logic                    is_cond_br;
    logic                    pred_taken;
    isa_pkg::addr_t          pred_target;
    logic                    enq_ready;
    logic                    enq_valid;
    logic                    stall;
    fetch_pkg::fetch_entry_t enq_entry;

    icache icache_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (pc_q),
        .refill_valid(refill_valid),
        .refill_data (refill_data),
        .hit         (hit),
        .block       (cache_block),
        .refill_req  (refill_req),
        .refill_addr (refill_addr)
    );

    // pc bit 2 picks the word, low word first
    assign slot       = pc_q[fetch_pkg::OFFSET_W-1];
    assign instr_word = cache_block[slot * isa_pkg::INSTR_W +: isa_pkg::INSTR_W];

    next_pc_predict npc_i (
        .instr      (instr_word),
        .pc         (pc_q),
        .is_cond_br (is_cond_br),
        .pred_taken (pred_taken),
        .pred_target(pred_target)
    );

    // miss or no room, hold the pc
    assign stall     = !hit || !enq_ready;
    assign enq_valid = hit && enq_ready && !redirect_valid;  // redirect kills this fetch

    always_comb begin
        if (redirect_valid) pc_d = redirect_pc;     // backend wins
        else if (stall)     pc_d = pc_q;
        else                pc_d = pred_target;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) pc_q <= fetch_pkg::RESET_PC;
        else        pc_q <= pc_d;
    end

    assign enq_entry.instr       = instr_word;
    assign enq_entry.pc          = pc_q;
    assign enq_entry.is_cond_br  = is_cond_br;
    assign enq_entry.pred_taken  = pred_taken;
    assign enq_entry.pred_target = pred_target;

    instr_fifo ififo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (redirect_valid),   // wrong path entries dropped
        .enq_valid(enq_valid),
        .enq_data (enq_entry),
        .deq_ready(dispatch_ready),
        .enq_ready(enq_ready),
        .deq_valid(instr_valid),
        .deq_data (instr_entry)
    );

    // dispatch sees a steady entry under back-pressure, only a redirect may drop it
    a_dispatch_hold : assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !dispatch_ready && !redirect_valid
        |=> instr_valid && $stable(instr_entry))
        else $error("ifu: dispatch entry changed while stalled");

endmodule

// File: dv/refill_mem_model.sv
module refill_mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  isa_pkg::addr_t    addr,
    output logic              valid,
    output fetch_pkg::block_t data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic           busy;
    int unsigned    wait_cnt;   // edges left until the answer
    isa_pkg::addr_t req_addr;

    function automatic isa_pkg::instr_t word_at(isa_pkg::addr_t a);
        isa_pkg::addr_t idx;
        logic [12:0]    b_imm;
        logic [20:0]    j_imm;
        idx = a >> 2;
        if (idx % 7 == 3) begin
            b_imm = -13'sd8;    // backward branch
            return {b_imm[12], b_imm[10:5], 5'd2, 5'd1, 3'b000, b_imm[4:1], b_imm[11],
                    isa_pkg::OPC_BRANCH};
        end
        if (idx % 11 == 5) begin
            b_imm = 13'd12;     // forward branch
            return {b_imm[12], b_imm[10:5], 5'd2, 5'd1, 3'b000, b_imm[4:1], b_imm[11],
                    isa_pkg::OPC_BRANCH};
        end
        if (idx % 13 == 9) begin
            j_imm = 21'd32;
            return {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], 5'd0, isa_pkg::OPC_JAL};
        end
        return {idx[11:0], 5'd1, 3'b000, 5'd1, 7'b001_0011};   // addi x1, x1, idx
    endfunction

    initial begin
        valid = 1'b0;
        data  = '0;
    end

    always @(posedge clk) begin
        valid <= 1'b0;   // one cycle pulse
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 1) begin
                valid <= 1'b1;
                data  <= {word_at(req_addr + 32'd4), word_at(req_addr)};  // low word first
                busy  <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (req && !valid) begin   // req still high on the answer edge
            busy     <= 1'b1;
            req_addr <= addr;
            wait_cnt <= $urandom_range(4, 1);
        end
    end

endmodule

// File: dv/ifu_tb.sv
module ifu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int             RUN_CYCLES   = 3000;
    localparam int             RESET_CYCLES = 8;
    localparam int             WATCHDOG_NS  = (RUN_CYCLES + 500) * 20;  // run plus margin
    localparam int unsigned    SEED         = 32'h5e64_aaaa;
    localparam isa_pkg::addr_t REGION_BASE  = 32'h0000_1000;   // 4 KB code region

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    redirect_valid;
    isa_pkg::addr_t          redirect_pc;
    logic                    refill_valid;
    fetch_pkg::block_t       refill_data;
    logic                    dispatch_ready;
    logic                    refill_req;
    isa_pkg::addr_t          refill_addr;
    logic                    instr_valid;
    fetch_pkg::fetch_entry_t instr_entry;

    isa_pkg::addr_t          exp_pc;       // reference next pc
    fetch_pkg::fetch_entry_t exp_entry;
    fetch_pkg::block_t       exp_block;
    int                      errors    = 0;
    int                      delivered = 0;

    always #10 clk = ~clk;

    ifu dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .refill_valid  (refill_valid),
        .refill_data   (refill_data),
        .dispatch_ready(dispatch_ready),
        .refill_req    (refill_req),
        .refill_addr   (refill_addr),
        .instr_valid   (instr_valid),
        .instr_entry   (instr_entry)
    );

    refill_mem_model mem_i (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (refill_req),
        .addr (refill_addr),
        .valid(refill_valid),
        .data (refill_data)
    );

    // reference memory content, word index picks the kind
    function automatic isa_pkg::instr_t mem_word(isa_pkg::addr_t a);
        isa_pkg::addr_t idx;
        logic [12:0]    b_imm;
        logic [20:0]    j_imm;
        idx   = a >> 2;
        b_imm = (idx % 7 == 3) ? 13'h1ff8 : 13'd12;  // -8 or +12
        j_imm = 21'd32;
        if (idx % 7 == 3 || idx % 11 == 5)
            return {b_imm[12], b_imm[10:5], 5'd2, 5'd1, 3'b000, b_imm[4:1], b_imm[11],
                    isa_pkg::OPC_BRANCH};
        if (idx % 13 == 9)
            return {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], 5'd0, isa_pkg::OPC_JAL};
        return {idx[11:0], 5'd1, 3'b000, 5'd1, 7'b001_0011};
    endfunction

    // btfn outcome per word kind, no decoding
    function automatic fetch_pkg::fetch_entry_t expect_entry(isa_pkg::addr_t pc);
        fetch_pkg::fetch_entry_t e;
        isa_pkg::addr_t          idx;
        idx           = pc >> 2;
        e.instr       = mem_word(pc);
        e.pc          = pc;
        e.is_cond_br  = (idx % 7 == 3) || (idx % 11 == 5);
        e.pred_taken  = (idx % 7 == 3) || (idx % 11 != 5 && idx % 13 == 9);
        e.pred_target = pc + 32'd4;
        if (idx % 7 == 3)
            e.pred_target = pc - 32'd8;
        else if (idx % 11 != 5 && idx % 13 == 9)
            e.pred_target = pc + 32'd32;   // jal
        return e;
    endfunction

    task automatic flag_mismatch(string msg);
        errors++;
        $display("CHECK FAILED @%0t: %s", $time, msg);
    endtask

    assign exp_entry = expect_entry(instr_entry.pc);
    assign exp_block = {mem_word(refill_addr + 32'd4), mem_word(refill_addr)};

    always @(posedge clk) begin
        if (!rst_n) exp_pc <= fetch_pkg::RESET_PC;
        else if (redirect_valid) exp_pc <= redirect_pc;   // redirect wins over a transfer
        else if (instr_valid && dispatch_ready) exp_pc <= exp_entry.pred_target;
        if (rst_n && instr_valid && dispatch_ready) delivered <= delivered + 1;
    end

    a_reset_idle : assert property (@(posedge clk) $rose(rst_n) |-> !instr_valid && !refill_req)
        else flag_mismatch("valid or refill_req high right after reset");
    a_pc_chain : assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && dispatch_ready |-> instr_entry.pc == exp_pc)
        else flag_mismatch($sformatf("pc %h, expected %h", instr_entry.pc, exp_pc));
    a_entry_content : assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> instr_entry == exp_entry)
        else flag_mismatch($sformatf("entry at pc %h wrong word or prediction", instr_entry.pc));
    a_flush : assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !instr_valid)
        else flag_mismatch("stale entry offered after redirect");
    a_hold : assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !dispatch_ready && !redirect_valid |=> instr_valid && $stable(instr_entry))
        else flag_mismatch("entry not held under back-pressure");
    a_refill_align : assert property (@(posedge clk) disable iff (!rst_n)
        refill_req |-> refill_addr[2:0] == 3'b000)
        else flag_mismatch($sformatf("refill_addr %h not block aligned", refill_addr));
    a_refill_hold : assert property (@(posedge clk) disable iff (!rst_n)
        refill_req && !refill_valid |=> refill_req && $stable(refill_addr))
        else flag_mismatch("refill request dropped or address moved");
    a_refill_data : assert property (@(posedge clk) disable iff (!rst_n)
        refill_valid |-> refill_data == exp_block)
        else flag_mismatch($sformatf("refill block for %h differs", refill_addr));

    initial begin
        int gap;
        void'($urandom(SEED));
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dispatch_ready = 1'b0;
        gap            = 60;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk);
            rst_n          <= (cyc >= RESET_CYCLES - 1);
            dispatch_ready <= ($urandom_range(99) < 70);   // ~70 % ready
            redirect_valid <= 1'b0;
            if (rst_n) begin
                gap--;
                if (gap == 0) begin
                    redirect_valid <= 1'b1;
                    redirect_pc    <= REGION_BASE + (32'($urandom_range(1023)) << 2);
                    gap = 60 + $urandom_range(60);
                end
            end
        end
        repeat (2) @(posedge clk);
        if (delivered == 0) begin
            errors++;
            $display("no entry was delivered to dispatch during the run");
        end
        $display("errors: %0d, entries delivered: %0d", errors, delivered);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: fetch_frontend.f
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/icache.sv
logic/next_pc_predict.sv
logic/instr_fifo.sv
logic/ifu.sv
dv/refill_mem_model.sv
dv/ifu_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - target: rtl
    files:
      - logic/isa_pkg.sv
      - logic/fetch_pkg.sv
      - logic/icache.sv
      - logic/next_pc_predict.sv
      - logic/instr_fifo.sv
      - logic/ifu.sv

  - target: test
    files:
      - dv/refill_mem_model.sv
      - dv/ifu_tb.sv
